// ==== hdl/matrix_params.svh ====
// matrix echo sizes
// baud divider, matrix dimensions, element range and store depth

`ifndef MATRIX_PARAMS_SVH
`define MATRIX_PARAMS_SVH

// uart bit time in clk cycles, small for simulation
`define CLKS_PER_BIT 16

// largest row or column count
`define MAX_DIM 5
`define MAX_ELEMS 25  // MAX_DIM squared

`define ELEM_MAX 9    // largest element value
`define NUM_SLOTS 2   // matrices held in the store

`endif

// ==== hdl/matrix_pkg.sv ====
// matrix echo types
// dimension, element, matrix, store slot and fill count types

`include "matrix_params.svh"

package matrix_pkg;

	typedef logic [2:0] dim_t;   // row or column count, 1..MAX_DIM
	typedef logic [7:0] elem_t;  // one element

	// one matrix, elems row-major from index 0, unused positions zero
	typedef struct packed {
		dim_t rows;
		dim_t cols;
		elem_t [`MAX_ELEMS-1:0] elems;
	} matrix_t;

	typedef logic [0:0] slot_t;  // store slot index
	typedef logic [1:0] count_t; // filled slots, 0..NUM_SLOTS

endpackage

// ==== hdl/uart_rx.sv ====
// uart_rx
// 8N1 receiver, samples each bit in its middle and strobes rx_done
// for one cycle per good frame. frames with a low stop bit are dropped

`timescale 1ns/1ps
`include "matrix_params.svh"

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       uart_rxd,
	output logic [7:0] rx_data,
	output logic       rx_done
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t   state;
	logic        rxd_meta, rxd_sync, rxd_prev; // sync chain + edge reg
	logic [15:0] clk_cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shift;

	assign rx_data = shift; // stable from last data bit until next frame

	// ======================================================================
	// line sync and frame fsm
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1; // idle line is high
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
			rx_done  <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (rxd_prev && !rxd_sync) state <= RX_START; // falling edge
				end
				RX_START: begin
					if (clk_cnt == 16'(`CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						state   <= rxd_sync ? RX_IDLE : RX_DATA; // glitch -> back to idle
					end else
						clk_cnt <= clk_cnt + 16'd1;
				end
				RX_DATA: begin
					if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) state <= RX_STOP;
					end else
						clk_cnt <= clk_cnt + 16'd1;
				end
				default: begin // stop bit
					if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
						rx_done <= rxd_sync; // only strobe on a high stop bit
						state   <= RX_IDLE;
					end else
						clk_cnt <= clk_cnt + 16'd1;
				end
			endcase
		end
	end

	// data shift, lsb arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && clk_cnt == 16'(`CLKS_PER_BIT - 1))
			shift <= {rxd_sync, shift[7:1]};
	end

	a_rx_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done held for more than one cycle");

endmodule

// ==== hdl/matrix_parser.sv ====
// matrix_parser
// turns received ascii into a matrix: rows, cols, then rows*cols
// element digits. separators are skipped, bad input pulses parse_error

`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_parser (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [7:0]        rx_data,
	input  logic              rx_done,
	output matrix_pkg::matrix_t matrix,
	output logic              matrix_valid,
	output logic              parse_error
);

	import matrix_pkg::*;

	typedef enum logic [1:0] {ST_ROWS, ST_COLS, ST_ELEMS} pstate_t;

	pstate_t  state;
	dim_t     rows_r, cols_r;
	logic [4:0] elem_idx, elem_total;       // element counter vs rows*cols
	elem_t [`MAX_ELEMS-1:0] elems_w, elems_next;
	logic [7:0] digit;
	logic     is_sep, is_digit, dim_ok, elem_ok, elem_wr, last_elem;

	// ======================================================================
	// byte classification
	// ======================================================================
	assign digit     = rx_data - 8'h30;
	assign is_sep    = (rx_data == 8'h20) || (rx_data == 8'h0D) || (rx_data == 8'h0A);
	assign is_digit  = (rx_data >= 8'h30) && (rx_data <= 8'h39);
	assign dim_ok    = (digit >= 8'd1) && (digit <= 8'(`MAX_DIM));
	assign elem_ok   = digit <= 8'(`ELEM_MAX);
	assign elem_wr   = rx_done && is_digit && elem_ok && (state == ST_ELEMS);
	assign last_elem = elem_idx == elem_total - 5'd1;

	// working array with the incoming element merged in
	always_comb begin
		elems_next = elems_w;
		if (elem_wr) elems_next[elem_idx] = digit;
	end

	// ======================================================================
	// token fsm
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ST_ROWS;
			rows_r       <= '0;
			cols_r       <= '0;
			elem_idx     <= '0;
			elem_total   <= '0;
			matrix_valid <= 1'b0;
			parse_error  <= 1'b0;
		end else begin
			matrix_valid <= 1'b0;
			parse_error  <= 1'b0;
			if (rx_done && !is_sep) begin
				if (!is_digit) begin
					parse_error <= 1'b1; // restart at row count
					state       <= ST_ROWS;
				end else begin
					case (state)
						ST_ROWS: begin
							if (dim_ok) begin
								rows_r <= digit[2:0];
								state  <= ST_COLS;
							end else
								parse_error <= 1'b1;
						end
						ST_COLS: begin
							if (dim_ok) begin
								cols_r     <= digit[2:0];
								elem_total <= 5'(rows_r) * 5'(digit[2:0]);
								elem_idx   <= '0;
								state      <= ST_ELEMS;
							end else begin
								parse_error <= 1'b1;
								state       <= ST_ROWS;
							end
						end
						default: begin
							if (!elem_ok) begin
								parse_error <= 1'b1;
								state       <= ST_ROWS;
							end else if (last_elem) begin
								matrix_valid <= 1'b1; // whole matrix in
								state        <= ST_ROWS;
							end else
								elem_idx <= elem_idx + 5'd1;
						end
					endcase
				end
			end
		end
	end

	// element array, cleared when a new matrix gets its column count
	always_ff @(posedge clk) begin
		if (rx_done && is_digit && dim_ok && state == ST_COLS)
			elems_w <= '0;
		else
			elems_w <= elems_next;
		if (elem_wr && last_elem) begin
			matrix.rows  <= rows_r;
			matrix.cols  <= cols_r;
			matrix.elems <= elems_next;
		end
	end

	a_valid_dims: assert property (@(posedge clk) disable iff (!rst_n)
		matrix_valid |-> (matrix.rows >= 3'd1 && matrix.rows <= 3'(`MAX_DIM) &&
		                  matrix.cols >= 3'd1 && matrix.cols <= 3'(`MAX_DIM)))
		else $error("matrix_valid with dimension out of range");

endmodule

// ==== hdl/matrix_store.sv ====
// matrix_store
// NUM_SLOTS matrix registers written round-robin, oldest overwritten,
// with a saturating fill count and a combinational read port

`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_store (
	input  logic                clk,
	input  logic                rst_n,
	input  matrix_pkg::matrix_t matrix,
	input  logic                matrix_valid,
	input  matrix_pkg::slot_t   rd_slot,
	output matrix_pkg::matrix_t rd_matrix,
	output logic                wr_done,
	output matrix_pkg::slot_t   wr_slot,
	output matrix_pkg::count_t  stored_count
);

	import matrix_pkg::*;

	matrix_t mem [`NUM_SLOTS]; // slot memory
	slot_t   wr_ptr;           // next slot to write

	always_ff @(posedge clk) begin
		if (matrix_valid) mem[wr_ptr] <= matrix;
	end

	assign rd_matrix = mem[rd_slot]; // printer reads same cycle

	// ======================================================================
	// write pointer, strobe and fill count
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr       <= '0;
			wr_done      <= 1'b0;
			wr_slot      <= '0;
			stored_count <= '0;
		end else begin
			wr_done <= matrix_valid; // one cycle after the write
			if (matrix_valid) begin
				wr_slot <= wr_ptr;
				if (wr_ptr == slot_t'(`NUM_SLOTS - 1))
					wr_ptr <= '0; // wrap, oldest goes next
				else
					wr_ptr <= slot_t'(wr_ptr + 1'b1);
				if (stored_count != count_t'(`NUM_SLOTS))
					stored_count <= stored_count + 2'd1;
			end
		end
	end

	a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
		stored_count <= count_t'(`NUM_SLOTS))
		else $error("stored_count above NUM_SLOTS");

endmodule

// ==== hdl/matrix_printer.sv ====
// matrix_printer
// prints the slot just written as ascii, digits split by single spaces,
// every row closed by CR LF, one byte per tx_start

`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_printer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_done,
	input  matrix_pkg::slot_t   wr_slot,
	output matrix_pkg::slot_t   rd_slot,
	input  matrix_pkg::matrix_t rd_matrix,
	input  logic                tx_busy,
	output logic                tx_start,
	output logic [7:0]          tx_data
);

	import matrix_pkg::*;

	typedef enum logic [1:0] {P_IDLE, P_SEND, P_GAP} pstate_t;
	typedef enum logic [1:0] {PH_DIGIT, PH_SPACE, PH_CR, PH_LF} phase_t;

	pstate_t    state;
	phase_t     phase;
	dim_t       row, col;
	logic [4:0] elem_idx;  // row-major position, row*cols + col
	logic [7:0] cur_byte;
	logic       send;

	// next byte of the text
	always_comb begin
		case (phase)
			PH_DIGIT: cur_byte = 8'h30 + rd_matrix.elems[elem_idx];
			PH_SPACE: cur_byte = 8'h20;
			PH_CR:    cur_byte = 8'h0D;
			default:  cur_byte = 8'h0A;
		endcase
	end

	assign send = (state == P_SEND) && !tx_busy;

	// ======================================================================
	// walk rows and columns
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= P_IDLE;
			phase    <= PH_DIGIT;
			row      <= '0;
			col      <= '0;
			elem_idx <= '0;
			rd_slot  <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				P_IDLE: begin
					if (wr_done) begin // busy -> this matrix is not echoed
						rd_slot  <= wr_slot;
						row      <= '0;
						col      <= '0;
						elem_idx <= '0;
						phase    <= PH_DIGIT;
						state    <= P_SEND;
					end
				end
				P_SEND: begin
					if (send) begin
						tx_start <= 1'b1;
						state    <= P_GAP;
						case (phase)
							PH_DIGIT: begin
								elem_idx <= elem_idx + 5'd1;
								phase <= (col == dim_t'(rd_matrix.cols - 1'b1)) ? PH_CR : PH_SPACE;
							end
							PH_SPACE: begin
								col   <= col + 3'd1;
								phase <= PH_DIGIT;
							end
							PH_CR: phase <= PH_LF;
							default: begin // LF closes the row
								if (row == dim_t'(rd_matrix.rows - 1'b1))
									state <= P_IDLE; // last LF
								row   <= row + 3'd1;
								col   <= '0;
								phase <= PH_DIGIT;
							end
						endcase
					end
				end
				default: state <= P_SEND; // tx_busy is valid again next cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (send) tx_data <= cur_byte;
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

// ==== hdl/uart_tx.sv ====
// uart_tx
// 8N1 transmitter, start bit, 8 data bits lsb first, stop bit,
// tx_busy high for the whole frame

`timescale 1ns/1ps
`include "matrix_params.svh"

module uart_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       uart_txd,
	output logic       tx_busy
);

	logic [9:0]  frame;   // bit 0 is the one on the line
	logic [15:0] clk_cnt;
	logic [3:0]  bit_cnt;
	logic        bit_end;

	assign bit_end = clk_cnt == 16'(`CLKS_PER_BIT - 1);

	// ======================================================================
	// bit timing
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_txd <= 1'b1;
			tx_busy  <= 1'b0;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy  <= 1'b1;
				uart_txd <= 1'b0; // start bit
				clk_cnt  <= '0;
				bit_cnt  <= '0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				tx_busy  <= 1'b0; // stop bit done
				uart_txd <= 1'b1;
			end else begin
				bit_cnt  <= bit_cnt + 4'd1;
				uart_txd <= frame[1]; // next bit
			end
		end else
			clk_cnt <= clk_cnt + 16'd1;
	end

	// frame shift register
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			frame <= {1'b1, tx_data, 1'b0};
		else if (tx_busy && bit_end)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

// ==== hdl/matrix_echo_top.sv ====
// matrix_echo_top
// uart receive -> parser -> matrix store -> printer -> uart transmit

`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_echo_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               uart_rxd,
	output logic               uart_txd,
	output logic               parse_error,
	output matrix_pkg::count_t stored_count
);

	import matrix_pkg::*;

	// ======================================================================
	// input side
	// ======================================================================
	logic [7:0] rx_data;
	logic       rx_done;
	matrix_t    parsed;
	logic       matrix_valid;

	uart_rx u_uart_rx (
		.clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd),
		.rx_data(rx_data), .rx_done(rx_done)
	);

	matrix_parser u_parser (
		.clk(clk), .rst_n(rst_n), .rx_data(rx_data), .rx_done(rx_done),
		.matrix(parsed), .matrix_valid(matrix_valid), .parse_error(parse_error)
	);

	// store and output side
	matrix_t    rd_matrix;
	slot_t      rd_slot, wr_slot;
	logic       wr_done;
	logic       tx_start, tx_busy;
	logic [7:0] tx_data;

	matrix_store u_store (
		.clk(clk), .rst_n(rst_n), .matrix(parsed), .matrix_valid(matrix_valid),
		.rd_slot(rd_slot), .rd_matrix(rd_matrix), .wr_done(wr_done),
		.wr_slot(wr_slot), .stored_count(stored_count)
	);

	matrix_printer u_printer (
		.clk(clk), .rst_n(rst_n), .wr_done(wr_done), .wr_slot(wr_slot),
		.rd_slot(rd_slot), .rd_matrix(rd_matrix), .tx_busy(tx_busy),
		.tx_start(tx_start), .tx_data(tx_data)
	);

	uart_tx u_uart_tx (
		.clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
		.uart_txd(uart_txd), .tx_busy(tx_busy)
	);

endmodule

// ==== test/tb_matrix_echo.sv ====
// tb_matrix_echo
// sends ascii matrices into the uart rx line, decodes the echo on uart_txd
// and checks it against a reference printout, plus parse errors and fill count

`timescale 1ns/1ps
`include "matrix_params.svh"

module tb_matrix_echo;

	import matrix_pkg::*;

	localparam int BIT_CLKS     = `CLKS_PER_BIT;
	localparam int GAP_TIMEOUT  = 40 * BIT_CLKS; // max cycles between echo bytes
	localparam int IDLE_TIMEOUT = 30 * BIT_CLKS;
	localparam int QUIET_WINDOW = 40 * BIT_CLKS; // no echo expected in here

	typedef logic [7:0] byte_q_t [$];

	logic    clk, rst_n, uart_rxd, uart_txd, parse_error;
	count_t  stored_count;

	byte_q_t     rx_q;           // bytes decoded from uart_txd
	byte_q_t     exp_q;          // bytes still expected
	int          err_pulses = 0; // parse_error pulses seen
	logic [15:0] lfsr_state;
	int          matrices_sent;  // valid matrices sent so far
	logic        mon_active;
	int          mon_cnt;
	logic [7:0]  mon_shift, cmp_got, cmp_want;

	matrix_echo_top dut (
		.clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd), .uart_txd(uart_txd),
		.parse_error(parse_error), .stored_count(stored_count)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk; // 20 ns period

	// ======================================================================
	// failure reporting and compare tasks
	// ======================================================================
	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s, got 0x%02h expected 0x%02h",
				$time, what, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_count(input count_t got, input count_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_error(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s, got %b expected %b", $time, what, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_line(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s, got %b expected %b", $time, what, got, exp);
			stop_with_fail();
		end
	endtask

	// galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = v * 2 + (lfsr_state[0] ? 1 : 0); // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// reference printout with digits split by spaces and CR LF after each row
	function automatic byte_q_t expected_echo(input matrix_t m);
		byte_q_t    q;
		logic [4:0] idx;
		q = {};
		for (int r = 0; r < int'(m.rows); r++) begin
			for (int c = 0; c < int'(m.cols); c++) begin
				idx = 5'(r * int'(m.cols) + c);
				q.push_back(8'h30 + m.elems[idx]);
				if (c < int'(m.cols) - 1) q.push_back(8'h20);
			end
			q.push_back(8'h0D);
			q.push_back(8'h0A);
		end
		return q;
	endfunction

	// store fill level after a number of valid matrices
	function automatic count_t expected_count(input int matrices);
		if (matrices >= `NUM_SLOTS)
			return count_t'(`NUM_SLOTS);
		return count_t'(matrices);
	endfunction

	// ======================================================================
	// uart driver
	// ======================================================================
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rxd <= frame[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	task automatic send_text(input string s);
		for (int i = 0; i < s.len(); i++) send_byte(s[i]);
	endtask

	task automatic send_separator(input logic random_seps);
		int v;
		int n;
		n = 1;
		if (random_seps) begin
			rand_bits(1, v);
			n = 1 + v; // sometimes two in a row
		end
		for (int i = 0; i < n; i++) begin
			v = 0;
			if (random_seps) rand_bits(2, v);
			case (v)
				2: send_byte(8'h0D);
				3: send_byte(8'h0A);
				default: send_byte(8'h20);
			endcase
		end
	endtask

	task automatic send_matrix(input matrix_t m, input logic random_seps);
		send_byte(8'h30 + 8'(m.rows));
		send_separator(random_seps);
		send_byte(8'h30 + 8'(m.cols));
		for (int i = 0; i < int'(m.rows) * int'(m.cols); i++) begin
			send_separator(random_seps);
			send_byte(8'h30 + m.elems[5'(i)]);
		end
	endtask

	// dim 0 picks random rows and cols
	task automatic random_matrix(input int dim, output matrix_t m);
		int v;
		m = '0;
		if (dim == 0) begin
			rand_bits(3, v);
			m.rows = dim_t'(v % `MAX_DIM + 1);
			rand_bits(3, v);
			m.cols = dim_t'(v % `MAX_DIM + 1);
		end else begin
			m.rows = dim_t'(dim);
			m.cols = dim_t'(dim);
		end
		for (int i = 0; i < int'(m.rows) * int'(m.cols); i++) begin
			rand_bits(4, v);
			m.elems[5'(i)] = elem_t'(v % (`ELEM_MAX + 1));
		end
	endtask

	// ======================================================================
	// waits, each with its own timeout
	// ======================================================================
	task automatic wait_echo();
		int idle;
		int last;
		idle = 0;
		last = exp_q.size();
		while (exp_q.size() > 0) begin
			@(posedge clk);
			if (exp_q.size() != last) begin
				last = exp_q.size();
				idle = 0;
			end else
				idle++;
			if (idle > GAP_TIMEOUT) begin
				$display("timeout: echo stalled with %0d bytes still expected", exp_q.size());
				stop_with_fail();
			end
		end
	endtask

	task automatic wait_idle();
		int high;
		int n;
		high = 0;
		n = 0;
		while (high < 10 * BIT_CLKS) begin // a whole frame time without a start bit
			if (n >= IDLE_TIMEOUT) begin
				$display("timeout: uart_txd never went idle after the echo");
				stop_with_fail();
			end
			@(posedge clk);
			n++;
			high = uart_txd ? high + 1 : 0;
		end
	endtask

	task automatic wait_error_pulse(input int errs);
		int n;
		n = 0;
		while (err_pulses == errs) begin
			if (n >= 2 * BIT_CLKS) begin
				$display("timeout: no parse_error pulse after a bad byte");
				stop_with_fail();
			end
			@(posedge clk);
			n++;
		end
	endtask

	// ======================================================================
	// test steps
	// ======================================================================
	task automatic run_matrix(input matrix_t m, input logic random_seps);
		byte_q_t q;
		int      errs;
		errs = err_pulses;
		q = expected_echo(m);
		foreach (q[i]) exp_q.push_back(q[i]);
		send_matrix(m, random_seps);
		wait_echo();
		wait_idle();
		if (rx_q.size() != 0) begin
			$display("echo carried %0d bytes more than expected", rx_q.size());
			stop_with_fail();
		end
		matrices_sent++;
		check_count(stored_count, expected_count(matrices_sent), "stored_count after echo");
		check_error(err_pulses != errs, 1'b0, "parse_error on a valid matrix");
	endtask

	task automatic bad_input(input string prefix, input logic [7:0] bad, input string what);
		int errs;
		errs = err_pulses;
		send_text(prefix);
		check_error(err_pulses != errs, 1'b0, {what, ": parse_error before the bad byte"});
		send_byte(bad);
		wait_error_pulse(errs);
		repeat (QUIET_WINDOW) @(posedge clk);
		check_error(err_pulses == errs + 1, 1'b1, {what, ": exactly one parse_error pulse"});
		if (rx_q.size() != 0) begin
			$display("%s: an echo appeared after malformed input", what);
			stop_with_fail();
		end
		check_count(stored_count, expected_count(matrices_sent),
			{what, ": stored_count unchanged"});
	endtask

	// ======================================================================
	// monitor, compare and error counter
	// ======================================================================
	always @(posedge clk) begin
		if (!rst_n) begin
			mon_active = 1'b0;
			mon_cnt    = 0;
		end else if (!mon_active) begin
			if (!uart_txd) begin // start bit seen
				mon_active = 1'b1;
				mon_cnt    = 0;
			end
		end else begin
			mon_cnt++;
			if (mon_cnt == BIT_CLKS / 2) begin
				if (uart_txd) begin
					$display("uart_txd start bit did not hold low");
					stop_with_fail();
				end
			end else if (mon_cnt > BIT_CLKS / 2 &&
			             (mon_cnt - BIT_CLKS / 2) % BIT_CLKS == 0) begin
				if (mon_cnt < BIT_CLKS / 2 + 9 * BIT_CLKS)
					mon_shift = {uart_txd, mon_shift[7:1]}; // lsb first
				else begin
					if (!uart_txd) begin
						$display("uart_txd stop bit was low");
						stop_with_fail();
					end
					rx_q.push_back(mon_shift);
					mon_active = 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (exp_q.size() > 0 && rx_q.size() > 0) begin
			cmp_got  = rx_q.pop_front();
			cmp_want = exp_q.pop_front();
			check_byte(cmp_got, cmp_want, "echo byte");
		end
	end

	always @(posedge clk) begin
		if (rst_n && parse_error) err_pulses = err_pulses + 1; // one cycle per pulse
	end

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		matrix_t m;
		rst_n         = 1'b0;
		uart_rxd      = 1'b1; // idle line
		lfsr_state    = 16'd49;
		matrices_sent = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// quiet after reset
		repeat (20 * BIT_CLKS) begin
			@(posedge clk);
			check_line(uart_txd, 1'b1, "uart_txd idle after reset");
			check_error(parse_error, 1'b0, "parse_error after reset");
			check_count(stored_count, 2'd0, "stored_count after reset");
		end

		// fixed 2x3
		m = '0;
		m.rows     = 3'd2;
		m.cols     = 3'd3;
		m.elems[0] = 8'd7;
		m.elems[1] = 8'd0;
		m.elems[2] = 8'd9;
		m.elems[3] = 8'd3;
		m.elems[4] = 8'd8;
		m.elems[5] = 8'd1;
		run_matrix(m, 1'b0);

		// random matrices with one 1x1 and one 5x5 among them
		for (int n = 0; n < 10; n++) begin
			if (n == 0)
				random_matrix(1, m);
			else if (n == 5)
				random_matrix(`MAX_DIM, m);
			else
				random_matrix(0, m);
			run_matrix(m, 1'b1);
		end

		// malformed input and then a good matrix again
		bad_input("2 2 1 3 ", 8'h78, "non-digit among elements");
		bad_input("", 8'h30, "row count 0");
		bad_input("3 ", 8'h36, "column count 6");
		bad_input("", 8'h36, "row count 6");
		random_matrix(0, m);
		run_matrix(m, 1'b1);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/matrix_pkg.sv
hdl/uart_rx.sv
hdl/matrix_parser.sv
hdl/matrix_store.sv
hdl/matrix_printer.sv
hdl/uart_tx.sv
hdl/matrix_echo_top.sv
test/tb_matrix_echo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the matrix echo testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_matrix_echo -o tb_matrix_echo
./obj_dir/tb_matrix_echo
